//--- acq_types_pkg.sv
`default_nettype none

package acq_types_pkg;

   // field widths of the acquisition datapath
   typedef logic [2:0]         code_shift_t;
   typedef logic signed [15:0] doppler_t;
   typedef logic signed [7:0]  corr_t;
   typedef logic signed [11:0] sum_t;
   typedef logic [23:0]        i2q2_t;

   typedef enum logic [1:0] {
      MODE_IDLE  = 2'd0,
      MODE_ACQ   = 2'd1,
      MODE_TRACK = 2'd2
   } mode_t;

   // carrier hypotheses searched in parallel
   typedef enum logic [1:0] {
      ARM_EARLY  = 2'd0,
      ARM_PROMPT = 2'd1,
      ARM_LATE   = 2'd2
   } arm_t;

   typedef enum logic [1:0] {
      STEP_SELECT  = 2'd0,
      STEP_COMPARE = 2'd1,
      STEP_UPDATE  = 2'd2
   } step_t;

   typedef struct packed {
      corr_t early_i;
      corr_t early_q;
      corr_t prompt_i;
      corr_t prompt_q;
      corr_t late_i;
      corr_t late_q;
   } corr_sample_t;

   typedef struct packed {
      i2q2_t early;
      i2q2_t prompt;
      i2q2_t late;
   } i2q2_set_t;

   // one code shift searched at three carrier offsets
   typedef struct packed {
      code_shift_t code_shift;
      doppler_t    dopp_early;
      doppler_t    dopp_prompt;
      doppler_t    dopp_late;
   } hyp_t;

   typedef struct packed {
      i2q2_t       peak_i2q2;
      doppler_t    peak_doppler;
      code_shift_t peak_code_shift;
   } acq_result_t;

endpackage

`default_nettype wire

//--- acq_cfg_pkg.sv
`default_nettype none

package acq_cfg_pkg;

   // last code shift of the sweep, wraps to 0 afterwards
   localparam acq_types_pkg::code_shift_t MAX_CODE_SHIFT = 3'd7;

   // starting carrier offsets of the three arms
   localparam acq_types_pkg::doppler_t DOPP_EARLY_START  = 16'sd1598;
   localparam acq_types_pkg::doppler_t DOPP_PROMPT_START = 16'sd0;
   localparam acq_types_pkg::doppler_t DOPP_LATE_START   = -16'sd1598;

   // step added to every arm after a full code sweep
   localparam acq_types_pkg::doppler_t DOPP_ACQ_INC = 16'sd4794;

   // sweep is done once the scored early offset reaches this
   localparam acq_types_pkg::doppler_t DOPP_MAX_INC = 16'sd6392;

   // samples integrated per energy
   localparam int unsigned ACC_LEN = 4;

endpackage

`default_nettype wire

//--- acq_accumulator.sv
`default_nettype none

module acq_accumulator (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         sample_valid,
   input  acq_types_pkg::corr_sample_t  sample,
   output logic                         accumulation_complete,
   output logic                         i2q2_valid,
   output acq_types_pkg::i2q2_set_t     energies
);

   typedef logic [$clog2(acq_cfg_pkg::ACC_LEN)-1:0] cnt_t;

   // index order: early i, early q, prompt i, prompt q, late i, late q
   acq_types_pkg::corr_t smp [6];
   acq_types_pkg::sum_t  acc_sum [6];
   acq_types_pkg::sum_t  hold_sum [6];
   cnt_t                 sample_cnt;
   logic                 last_sample;

   function automatic acq_types_pkg::i2q2_t energy(input acq_types_pkg::sum_t i,
                                                   input acq_types_pkg::sum_t q);
      logic signed [$bits(acq_types_pkg::i2q2_t)-1:0] iw;
      logic signed [$bits(acq_types_pkg::i2q2_t)-1:0] qw;
      iw = i;
      qw = q;
      return acq_types_pkg::i2q2_t'(iw * iw) + acq_types_pkg::i2q2_t'(qw * qw);
   endfunction

   assign smp[0] = sample.early_i;
   assign smp[1] = sample.early_q;
   assign smp[2] = sample.prompt_i;
   assign smp[3] = sample.prompt_q;
   assign smp[4] = sample.late_i;
   assign smp[5] = sample.late_q;

   assign last_sample = sample_valid &&
                        (sample_cnt == cnt_t'(acq_cfg_pkg::ACC_LEN - 1));

   // running sums restart right after the last sample of a period
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sample_cnt <= '0;
         for (int k = 0; k < 6; k++) begin
            acc_sum[k] <= '0;
         end
      end else if (sample_valid) begin
         if (last_sample) begin
            sample_cnt <= '0;
            for (int k = 0; k < 6; k++) begin
               acc_sum[k] <= '0;
            end
         end else begin
            sample_cnt <= sample_cnt + cnt_t'(1);
            for (int k = 0; k < 6; k++) begin
               acc_sum[k] <= acc_sum[k] + acq_types_pkg::sum_t'(smp[k]);
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         accumulation_complete <= 1'b0;
         i2q2_valid            <= 1'b0;
      end else begin
         accumulation_complete <= last_sample;
         i2q2_valid            <= accumulation_complete;
      end
   end

   // holding stage frees the sums while the squares are formed
   always_ff @(posedge clk) begin
      if (last_sample) begin
         for (int k = 0; k < 6; k++) begin
            hold_sum[k] <= acc_sum[k] + acq_types_pkg::sum_t'(smp[k]);
         end
      end
      if (accumulation_complete) begin
         energies.early  <= energy(hold_sum[0], hold_sum[1]);
         energies.prompt <= energy(hold_sum[2], hold_sum[3]);
         energies.late   <= energy(hold_sum[4], hold_sum[5]);
      end
   end

endmodule

`default_nettype wire

//--- code_slewer.sv
`default_nettype none

module code_slewer (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        seek_en,
   input  acq_types_pkg::code_shift_t  target,
   output logic                        seeking,
   output acq_types_pkg::code_shift_t  code_phase
);

   // busy whenever enabled and not yet on target
   assign seeking = seek_en && (code_phase != target);

   // one chip per clock, forward only
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         code_phase <= '0;
      end else if (seeking) begin
         if (code_phase == acq_cfg_pkg::MAX_CODE_SHIFT) begin
            code_phase <= '0;
         end else begin
            code_phase <= code_phase + acq_types_pkg::code_shift_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- acq_sequencer.sv
`default_nettype none

module acq_sequencer (
   input  logic                  clk,
   input  logic                  arst_n,
   input  acq_types_pkg::mode_t  mode,
   input  logic                  seeking,
   input  logic                  accumulation_complete,
   input  logic                  update_done,
   output logic                  seek_en,
   output acq_types_pkg::hyp_t   doppler,
   output logic                  restart,
   output logic                  score_req,
   output acq_types_pkg::hyp_t   scored_hyp,
   output logic                  acquisition_complete
);

   logic mode_acq_q;
   logic start_acq;
   logic acq_active;
   logic active;
   logic ignore_update;
   logic acc_complete_q;
   logic seek_complete;
   logic advance;
   logic last_code;
   logic final_hyp;

   // code phase must already sit on target right after a period ends
   assign seek_complete = !seeking && acc_complete_q;

   // only a settled, clean period moves the sweep forward
   assign advance   = active && accumulation_complete && !ignore_update;
   assign score_req = advance;
   assign last_code = doppler.code_shift == acq_cfg_pkg::MAX_CODE_SHIFT;

   assign final_hyp = scored_hyp.code_shift == acq_cfg_pkg::MAX_CODE_SHIFT &&
                      scored_hyp.dopp_early >= acq_cfg_pkg::DOPP_MAX_INC;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mode_acq_q     <= 1'b0;
         start_acq      <= 1'b0;
         acc_complete_q <= 1'b0;
      end else begin
         mode_acq_q     <= mode == acq_types_pkg::MODE_ACQ;
         start_acq      <= (mode == acq_types_pkg::MODE_ACQ) && !mode_acq_q;
         acc_complete_q <= accumulation_complete;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         restart       <= 1'b0;
         acq_active    <= 1'b0;
         active        <= 1'b0;
         ignore_update <= 1'b0;
         seek_en       <= 1'b0;
      end else begin
         // data in flight still belongs to the old sweep until a period ends
         if (start_acq) begin
            restart <= 1'b1;
         end else if (accumulation_complete) begin
            restart <= 1'b0;
         end

         // a completion from the previous sweep is still up while restart clears it
         if (start_acq) begin
            acq_active <= 1'b1;
         end else if (acquisition_complete && !restart) begin
            acq_active <= 1'b0;
         end

         if (!acq_active) begin
            active <= 1'b0;
         end else if (seek_en && seek_complete) begin
            active <= 1'b1;
         end else if (accumulation_complete) begin
            active <= 1'b0;
         end

         // stretched one cycle past restart so the mixed period is dropped
         if (start_acq || restart) begin
            ignore_update <= 1'b1;
         end else if (acc_complete_q) begin
            ignore_update <= 1'b0;
         end

         // held for the whole period when the target is not reached at once
         if (accumulation_complete) begin
            seek_en <= 1'b1;
         end else if (seek_complete) begin
            seek_en <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         doppler <= '0;
      end else if (restart) begin
         doppler.code_shift  <= '0;
         doppler.dopp_early  <= acq_cfg_pkg::DOPP_EARLY_START;
         doppler.dopp_prompt <= acq_cfg_pkg::DOPP_PROMPT_START;
         doppler.dopp_late   <= acq_cfg_pkg::DOPP_LATE_START;
      end else if (advance) begin
         if (last_code) begin
            doppler.code_shift  <= '0;
            doppler.dopp_early  <= doppler.dopp_early + acq_cfg_pkg::DOPP_ACQ_INC;
            doppler.dopp_prompt <= doppler.dopp_prompt + acq_cfg_pkg::DOPP_ACQ_INC;
            doppler.dopp_late   <= doppler.dopp_late + acq_cfg_pkg::DOPP_ACQ_INC;
         end else begin
            doppler.code_shift <= doppler.code_shift + acq_types_pkg::code_shift_t'(1);
         end
      end
   end

   // hypothesis of the period handed to the peak search
   always_ff @(posedge clk) begin
      if (advance) begin
         scored_hyp <= doppler;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acquisition_complete <= 1'b0;
      end else if (restart) begin
         acquisition_complete <= 1'b0;
      end else if (update_done && final_hyp) begin
         acquisition_complete <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- peak_search.sv
`default_nettype none

module peak_search (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         restart,
   input  logic                         score_req,
   input  logic                         i2q2_valid,
   input  acq_types_pkg::i2q2_set_t     energies,
   input  acq_types_pkg::hyp_t          scored_hyp,
   output logic                         update_done,
   output acq_types_pkg::acq_result_t   result
);

   logic                     pending;
   logic                     updating;
   logic                     update_last;
   logic                     greater;
   logic                     new_peak;
   acq_types_pkg::step_t     step;
   acq_types_pkg::arm_t      sel;
   acq_types_pkg::i2q2_t     next_value;
   acq_types_pkg::i2q2_t     arm_energy;
   acq_types_pkg::doppler_t  arm_doppler;

   assign update_last = updating && sel == acq_types_pkg::ARM_LATE &&
                        step == acq_types_pkg::STEP_UPDATE;
   assign new_peak    = updating && step == acq_types_pkg::STEP_UPDATE && greater;

   always_comb begin
      unique case (sel)
         acq_types_pkg::ARM_EARLY: begin
            arm_energy  = energies.early;
            arm_doppler = scored_hyp.dopp_early;
         end
         acq_types_pkg::ARM_PROMPT: begin
            arm_energy  = energies.prompt;
            arm_doppler = scored_hyp.dopp_prompt;
         end
         default: begin
            arm_energy  = energies.late;
            arm_doppler = scored_hyp.dopp_late;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending     <= 1'b0;
         updating    <= 1'b0;
         step        <= acq_types_pkg::STEP_SELECT;
         sel         <= acq_types_pkg::ARM_EARLY;
         update_done <= 1'b0;
      end else begin
         // the energies of a scored period follow one cycle later
         if (score_req) begin
            pending <= 1'b1;
         end else if (i2q2_valid) begin
            pending <= 1'b0;
         end

         if (pending && i2q2_valid) begin
            updating <= 1'b1;
         end else if (update_last) begin
            updating <= 1'b0;
         end

         if (pending) begin
            step <= acq_types_pkg::STEP_SELECT;
            sel  <= acq_types_pkg::ARM_EARLY;
         end else if (updating) begin
            unique case (step)
               acq_types_pkg::STEP_SELECT:  step <= acq_types_pkg::STEP_COMPARE;
               acq_types_pkg::STEP_COMPARE: step <= acq_types_pkg::STEP_UPDATE;
               default:                     step <= acq_types_pkg::STEP_SELECT;
            endcase
            if (step == acq_types_pkg::STEP_UPDATE) begin
               unique case (sel)
                  acq_types_pkg::ARM_EARLY:  sel <= acq_types_pkg::ARM_PROMPT;
                  acq_types_pkg::ARM_PROMPT: sel <= acq_types_pkg::ARM_LATE;
                  default:                   sel <= acq_types_pkg::ARM_EARLY;
               endcase
            end
         end

         update_done <= update_last;
      end
   end

   // select then compare, energies stay put for the whole walk
   always_ff @(posedge clk) begin
      if (updating && step == acq_types_pkg::STEP_SELECT) begin
         next_value <= arm_energy;
      end
      if (updating && step == acq_types_pkg::STEP_COMPARE) begin
         greater <= next_value > result.peak_i2q2;
      end
   end

   // equal energies keep the earlier peak
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (restart) begin
         result <= '0;
      end else if (new_peak) begin
         result.peak_i2q2       <= next_value;
         result.peak_doppler    <= arm_doppler;
         result.peak_code_shift <= scored_hyp.code_shift;
      end
   end

endmodule

`default_nettype wire

//--- acq_top.sv
`default_nettype none

module acq_top (
   input  logic                         clk,
   input  logic                         arst_n,
   input  acq_types_pkg::mode_t         mode,
   input  logic                         sample_valid,
   input  acq_types_pkg::corr_sample_t  sample,
   output acq_types_pkg::code_shift_t   code_phase,
   output acq_types_pkg::hyp_t          doppler,
   output logic                         acquisition_complete,
   output acq_types_pkg::acq_result_t   result
);

   logic                      accumulation_complete;
   logic                      i2q2_valid;
   acq_types_pkg::i2q2_set_t  energies;
   logic                      seek_en;
   logic                      seeking;
   logic                      restart;
   logic                      score_req;
   acq_types_pkg::hyp_t       scored_hyp;
   logic                      update_done;

   acq_accumulator u_accumulator (
      .clk                   (clk),
      .arst_n                (arst_n),
      .sample_valid          (sample_valid),
      .sample                (sample),
      .accumulation_complete (accumulation_complete),
      .i2q2_valid            (i2q2_valid),
      .energies              (energies)
   );

   // slews toward the code shift currently being searched
   code_slewer u_slewer (
      .clk        (clk),
      .arst_n     (arst_n),
      .seek_en    (seek_en),
      .target     (doppler.code_shift),
      .seeking    (seeking),
      .code_phase (code_phase)
   );

   acq_sequencer u_sequencer (
      .clk                   (clk),
      .arst_n                (arst_n),
      .mode                  (mode),
      .seeking               (seeking),
      .accumulation_complete (accumulation_complete),
      .update_done           (update_done),
      .seek_en               (seek_en),
      .doppler               (doppler),
      .restart               (restart),
      .score_req             (score_req),
      .scored_hyp            (scored_hyp),
      .acquisition_complete  (acquisition_complete)
   );

   peak_search u_peak_search (
      .clk         (clk),
      .arst_n      (arst_n),
      .restart     (restart),
      .score_req   (score_req),
      .i2q2_valid  (i2q2_valid),
      .energies    (energies),
      .scored_hyp  (scored_hyp),
      .update_done (update_done),
      .result      (result)
   );

endmodule

`default_nettype wire

//--- tb_acq.sv
`default_nettype none

module tb_acq;

   timeunit 1ns;
   timeprecision 100ps;

   // one period is 4 strobes of 4 clocks, each hypothesis takes a slew and a scored period
   localparam int SWEEP_CYCLES = 16 * 16 * 2;
   localparam int WAIT_LIMIT   = 3 * SWEEP_CYCLES + 100;
   // about five sweeps of tests in total, plus margin
   localparam int RUN_CYCLES   = 6 * SWEEP_CYCLES + 1000;

   logic                         clk;
   logic                         arst_n;
   acq_types_pkg::mode_t         mode;
   logic                         sample_valid;
   acq_types_pkg::corr_sample_t  sample;
   acq_types_pkg::code_shift_t   code_phase;
   acq_types_pkg::hyp_t          doppler;
   logic                         acquisition_complete;
   acq_types_pkg::acq_result_t   result;

   // correlator table, slot is doppler step * 3 + arm
   acq_types_pkg::corr_t tab_i [8][6];
   acq_types_pkg::corr_t tab_q [8][6];

   string  test_name;
   int     check_count;
   int     error_count;
   int     timeout_count;
   integer seed;

   acq_top uut (
      .clk                  (clk),
      .arst_n               (arst_n),
      .mode                 (mode),
      .sample_valid         (sample_valid),
      .sample               (sample),
      .code_phase           (code_phase),
      .doppler              (doppler),
      .acquisition_complete (acquisition_complete),
      .result               (result)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic acq_types_pkg::doppler_t slot_doppler(input int slot);
      acq_types_pkg::doppler_t base;
      case (slot % 3)
         0:       base = acq_cfg_pkg::DOPP_EARLY_START;
         1:       base = acq_cfg_pkg::DOPP_PROMPT_START;
         default: base = acq_cfg_pkg::DOPP_LATE_START;
      endcase
      return base + acq_types_pkg::doppler_t'((slot / 3) * acq_cfg_pkg::DOPP_ACQ_INC);
   endfunction

   // -1 for offsets outside the searched grid
   function automatic int doppler_slot(input acq_types_pkg::doppler_t d);
      for (int s = 0; s < 6; s++) begin
         if (slot_doppler(s) == d) begin
            return s;
         end
      end
      return -1;
   endfunction

   function automatic acq_types_pkg::corr_t table_value(input logic is_q,
                                                        input acq_types_pkg::code_shift_t cp,
                                                        input acq_types_pkg::doppler_t d);
      int s;
      s = doppler_slot(d);
      if (s < 0) begin
         return '0;
      end
      return is_q ? tab_q[cp][s] : tab_i[cp][s];
   endfunction

   function automatic acq_types_pkg::corr_sample_t model_sample(
         input acq_types_pkg::code_shift_t cp, input acq_types_pkg::hyp_t d);
      acq_types_pkg::corr_sample_t s;
      s.early_i  = table_value(1'b0, cp, d.dopp_early);
      s.early_q  = table_value(1'b1, cp, d.dopp_early);
      s.prompt_i = table_value(1'b0, cp, d.dopp_prompt);
      s.prompt_q = table_value(1'b1, cp, d.dopp_prompt);
      s.late_i   = table_value(1'b0, cp, d.dopp_late);
      s.late_q   = table_value(1'b1, cp, d.dopp_late);
      return s;
   endfunction

   function automatic acq_types_pkg::i2q2_t entry_energy(input int code, input int slot);
      int i;
      int q;
      i = int'(tab_i[code][slot]) * int'(acq_cfg_pkg::ACC_LEN);
      q = int'(tab_q[code][slot]) * int'(acq_cfg_pkg::ACC_LEN);
      return acq_types_pkg::i2q2_t'(i * i + q * q);
   endfunction

   // strictly greater wins, so the earliest of equal energies stays
   function automatic acq_types_pkg::acq_result_t expected_winner();
      acq_types_pkg::acq_result_t best;
      best = '0;
      for (int st = 0; st < 2; st++) begin
         for (int c = 0; c <= int'(acq_cfg_pkg::MAX_CODE_SHIFT); c++) begin
            for (int a = 0; a < 3; a++) begin
               if (entry_energy(c, st * 3 + a) > best.peak_i2q2) begin
                  best.peak_i2q2       = entry_energy(c, st * 3 + a);
                  best.peak_doppler    = slot_doppler(st * 3 + a);
                  best.peak_code_shift = acq_types_pkg::code_shift_t'(c);
               end
            end
         end
      end
      return best;
   endfunction

   // correlator stand-in, one strobe every 4 clocks
   initial begin
      sample_valid = 1'b0;
      sample       = '0;
      @(posedge arst_n);
      forever begin
         @(posedge clk);
         #2;
         sample_valid = 1'b1;
         sample       = model_sample(code_phase, doppler);
         @(posedge clk);
         #2;
         sample_valid = 1'b0;
         repeat (2) @(posedge clk);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic note_timeout(input string what);
      timeout_count++;
      $display("Timeout in %s: %s", test_name, what);
   endtask

   task automatic check_result(input string what, input acq_types_pkg::acq_result_t exp,
                               input acq_types_pkg::acq_result_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Mismatch in %s, %s: expected energy %0d doppler %0d code %0d, %s",
                  test_name, what, exp.peak_i2q2, exp.peak_doppler, exp.peak_code_shift,
                  $sformatf("actual energy %0d doppler %0d code %0d",
                            act.peak_i2q2, act.peak_doppler, act.peak_code_shift));
      end
   endtask

   task automatic check_hyp(input string what, input acq_types_pkg::hyp_t exp,
                            input acq_types_pkg::hyp_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Mismatch in %s, %s: expected code %0d dopp %0d/%0d/%0d, %s",
                  test_name, what, exp.code_shift, exp.dopp_early, exp.dopp_prompt,
                  exp.dopp_late, $sformatf("actual code %0d dopp %0d/%0d/%0d",
                  act.code_shift, act.dopp_early, act.dopp_prompt, act.dopp_late));
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic fill_background();
      for (int c = 0; c < 8; c++) begin
         for (int s = 0; s < 6; s++) begin
            tab_i[c][s] = acq_types_pkg::corr_t'(c + 2 * s + 1);
            tab_q[c][s] = acq_types_pkg::corr_t'(3 - c + s);
         end
      end
   endtask

   task automatic plant_entry(input int code, input int slot,
                              input acq_types_pkg::corr_t i, input acq_types_pkg::corr_t q);
      tab_i[code][slot] = i;
      tab_q[code][slot] = q;
   endtask

   task automatic wait_for_complete(input logic level);
      int n;
      n = 0;
      while (acquisition_complete !== level && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (acquisition_complete !== level) begin
         note_timeout($sformatf("acquisition_complete never went to %b", level));
      end
   endtask

   // leave acquisition, come back, and wait until the old completion is cleared
   task automatic start_acquisition();
      mode = acq_types_pkg::MODE_TRACK;
      repeat (2) next_cycle();
      mode = acq_types_pkg::MODE_ACQ;
      wait_for_complete(1'b0);
   endtask

   task automatic test_reset_idle();
      test_name = "test_reset_idle";
      mode = acq_types_pkg::MODE_IDLE;
      repeat (50) begin
         next_cycle();
         check_bit("acquisition_complete", 1'b0, acquisition_complete);
         check_result("result", '0, result);
         check_hyp("doppler", '0, doppler);
      end
   endtask

   task automatic test_planted_peak();
      acq_types_pkg::acq_result_t exp;
      test_name = "test_planted_peak";
      fill_background();
      // code 5, late arm of the second step
      plant_entry(5, 5, 8'sd100, -8'sd90);
      exp.peak_i2q2       = entry_energy(5, 5);
      exp.peak_doppler    = slot_doppler(5);
      exp.peak_code_shift = 3'd5;
      start_acquisition();
      wait_for_complete(1'b1);
      check_result("peak", exp, result);
   endtask

   task automatic test_tie_order();
      acq_types_pkg::acq_result_t exp;
      test_name = "test_tie_order";
      fill_background();
      plant_entry(2, 1, 8'sd40, -8'sd30);
      plant_entry(6, 3, -8'sd30, 8'sd40);
      exp.peak_i2q2       = entry_energy(2, 1);
      exp.peak_doppler    = slot_doppler(1);
      exp.peak_code_shift = 3'd2;
      start_acquisition();
      wait_for_complete(1'b1);
      check_result("peak", exp, result);
   endtask

   task automatic test_start_values();
      acq_types_pkg::hyp_t start_hyp;
      acq_types_pkg::hyp_t first_hyp;
      int                  n;
      test_name = "test_start_values";
      start_hyp.code_shift  = '0;
      start_hyp.dopp_early  = acq_cfg_pkg::DOPP_EARLY_START;
      start_hyp.dopp_prompt = acq_cfg_pkg::DOPP_PROMPT_START;
      start_hyp.dopp_late   = acq_cfg_pkg::DOPP_LATE_START;
      first_hyp = start_hyp;
      first_hyp.code_shift = 3'd1;
      fill_background();
      // large peak in the first step, the restart test must lose it
      plant_entry(3, 0, 8'sd120, 8'sd110);
      start_acquisition();
      check_hyp("doppler at start", start_hyp, doppler);
      n = 0;
      while (code_phase !== '0 && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      check_bit("code_phase at 0", 1'b1, code_phase == '0);
      // start values hold until the first scored period
      n = 0;
      while (doppler === start_hyp && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      check_hyp("doppler after first score", first_hyp, doppler);
   endtask

   task automatic test_restart();
      acq_types_pkg::acq_result_t exp;
      int                         n;
      test_name = "test_restart";
      n = 0;
      while (doppler.dopp_early !== slot_doppler(3) && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (doppler.dopp_early !== slot_doppler(3)) begin
         note_timeout("sweep never reached the second doppler step");
      end
      fill_background();
      plant_entry(4, 4, 8'sd60, -8'sd50);
      exp.peak_i2q2       = entry_energy(4, 4);
      exp.peak_doppler    = slot_doppler(4);
      exp.peak_code_shift = 3'd4;
      start_acquisition();
      wait_for_complete(1'b1);
      check_result("peak after restart", exp, result);
   endtask

   task automatic test_random_energies();
      test_name = "test_random_energies";
      for (int c = 0; c < 8; c++) begin
         for (int s = 0; s < 6; s++) begin
            tab_i[c][s] = acq_types_pkg::corr_t'($random(seed));
            tab_q[c][s] = acq_types_pkg::corr_t'($random(seed));
         end
      end
      start_acquisition();
      wait_for_complete(1'b1);
      check_result("peak", expected_winner(), result);
   endtask

   task automatic report_summary();
      $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
               check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
   endtask

   initial begin
      repeat (RUN_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
      timeout_count++;
      report_summary();
      $finish;
   end

   initial begin
      arst_n        = 1'b0;
      mode          = acq_types_pkg::MODE_IDLE;
      check_count   = 0;
      error_count   = 0;
      timeout_count = 0;
      seed          = 32'h0203347e;
      test_name     = "reset";
      fill_background();
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;
      test_reset_idle();
      test_planted_peak();
      test_tie_order();
      test_start_values();
      test_restart();
      test_random_energies();
      report_summary();
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
acq_types_pkg.sv
acq_cfg_pkg.sv
acq_accumulator.sv
code_slewer.sv
acq_sequencer.sv
peak_search.sv
acq_top.sv
tb_acq.sv
